// ==== src/cpu_ctrl_pkg.sv ====
/*
 * cpu control package
 * sequencer phases, word-address width and execute-stage result bundle
 */
package cpu_ctrl_pkg;

	// word address, bits 31 down to 2
	localparam int adr_w = 30;

	// multicycle phases of one instruction
	typedef enum logic [2:0] {
		idle    = 3'd0,
		fetch   = 3'd1,
		decode  = 3'd2,
		execute = 3'd3,
		pc_upd  = 3'd4
	} cpu_phase_e;

	// execute-stage result, valid in execute and pc_upd
	typedef struct packed {
		logic jmp_condition;
		logic ecall;
		logic exception;
		logic mret;
		logic sret;
		logic uret;
		logic [adr_w+1:2] jmp_adr;
	} ex_result_t;

endpackage

// ==== src/trap_pkg.sv ====
/*
 * trap package
 * csr write port, interrupt signals and trap vectors for the pc stage
 */
package trap_pkg;

	// registers reachable through the csr write port
	typedef enum logic [2:0] {
		csr_mtvec   = 3'd0,
		csr_mepc    = 3'd1,
		csr_sepc    = 3'd2,
		csr_irq_en  = 3'd3,
		csr_frc_cmp = 3'd4
	} csr_sel_e;

	// en is a one-cycle strobe
	typedef struct packed {
		logic en;
		csr_sel_e sel;
		logic [31:0] data;
	} csr_wr_t;

	typedef struct packed {
		logic level;
		logic one_shot;
	} irq_t;

	// word addresses only
	typedef struct packed {
		logic [31:2] mtvec;
		logic [31:2] mepc;
		logic [31:2] sepc;
	} trap_vec_t;

endpackage

// ==== src/cpu_state_seq.sv ====
/*
 * cpu state sequencer
 * steps fetch, decode, execute and pc update with start and stall handling
 */
`timescale 1ns/10ps

module cpu_state_seq (
	input logic clk,
	input logic rst_n,
	input logic cpu_start,
	input logic stall,
	output logic cpu_stat_pc
);
	import cpu_ctrl_pkg::*;

	cpu_phase_e phase;
	cpu_phase_e phase_nxt;
	logic upd_first;

	// idle waits for cpu_start, the rest hold on stall
	always_comb begin
		phase_nxt = phase;
		case (phase)
			idle: if (cpu_start) phase_nxt = fetch;
			fetch: if (!stall) phase_nxt = decode;
			decode: if (!stall) phase_nxt = execute;
			execute: if (!stall) phase_nxt = pc_upd;
			pc_upd: if (!stall) phase_nxt = fetch;
			default: phase_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			phase <= idle;
		else
			phase <= phase_nxt;
	end

	// high only in the first pc_upd cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			upd_first <= 1'b1;
		else
			upd_first <= (phase != pc_upd);
	end

	// a stalled pc_upd must not repeat the update
	assign cpu_stat_pc = (phase == pc_upd) & upd_first;

	a_stat_pc_single: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_stat_pc |=> !cpu_stat_pc)
		else $error("cpu_stat_pc held for more than one cycle");

endmodule

// ==== src/frc_timer.sv ====
/*
 * free-running timer
 * 32-bit counter with a csr-written compare and a registered leq flag
 */
`timescale 1ns/10ps

module frc_timer (
	input logic clk,
	input logic rst_n,
	input trap_pkg::csr_wr_t csr_wr,
	output logic frc_leq
);
	import trap_pkg::*;

	logic [31:0] frc_cntr;
	logic [31:0] frc_cmp;

	// counts every cycle, wraps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frc_cntr <= 32'd0;
		else
			frc_cntr <= frc_cntr + 32'd1;
	end

	// starts at max so no timer trap after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frc_cmp <= 32'hffff_ffff;
		else if (csr_wr.en && (csr_wr.sel == csr_frc_cmp))
			frc_cmp <= csr_wr.data;
	end

	// a large compare value drops the flag again
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frc_leq <= 1'b0;
		else
			frc_leq <= (frc_cmp <= frc_cntr);
	end

endmodule

// ==== src/trap_csr_regs.sv ====
/*
 * trap csr registers
 * mtvec, mepc, sepc and irq enable, trap capture and interrupt one-shot
 */
`timescale 1ns/10ps

module trap_csr_regs (
	input logic clk,
	input logic rst_n,
	input trap_pkg::csr_wr_t csr_wr,
	input logic irq_in,
	input logic trap_take,
	input logic [31:2] pc_excep,
	output trap_pkg::irq_t irq,
	output trap_pkg::trap_vec_t vec
);
	import trap_pkg::*;

	logic [31:2] mtvec_r;
	logic [31:2] mepc_r;
	logic [31:2] sepc_r;
	logic irq_en;
	logic irq_sync;
	logic irq_sync_d;
	logic wr_mepc;

	assign wr_mepc = csr_wr.en & (csr_wr.sel == csr_mepc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtvec_r <= '0;
			sepc_r <= '0;
			irq_en <= 1'b0;
		end else if (csr_wr.en) begin
			// low two bits dropped, word address only
			if (csr_wr.sel == csr_mtvec)
				mtvec_r <= csr_wr.data[31:2];
			if (csr_wr.sel == csr_sepc)
				sepc_r <= csr_wr.data[31:2];
			if (csr_wr.sel == csr_irq_en)
				irq_en <= csr_wr.data[0];
		end
	end

	// trap capture wins over a csr write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mepc_r <= '0;
		else if (trap_take)
			mepc_r <= pc_excep;
		else if (wr_mepc)
			mepc_r <= csr_wr.data[31:2];
	end

	// irq_in sampled, then edge detected
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_sync <= 1'b0;
			irq_sync_d <= 1'b0;
		end else begin
			irq_sync <= irq_in;
			irq_sync_d <= irq_sync;
		end
	end

	assign irq.level = irq_sync & irq_en;
	assign irq.one_shot = irq_sync & ~irq_sync_d & irq_en;
	assign vec = '{mtvec: mtvec_r, mepc: mepc_r, sepc: sepc_r};

	a_mepc_collide: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_take && wr_mepc))
		else $warning("csr write to mepc lost to trap capture");

endmodule

// ==== src/pc_stage.sv ====
/*
 * pc stage
 * next word address, start load, interrupt and timer latches, exception pc
 */
`timescale 1ns/10ps

module pc_stage (
	input logic clk,
	input logic rst_n,
	input logic cpu_start,
	input logic cpu_stat_pc,
	input logic [31:2] cpu_start_adr,
	input cpu_ctrl_pkg::ex_result_t ex_result,
	input trap_pkg::irq_t irq,
	input logic frc_leq,
	input trap_pkg::trap_vec_t vec,
	output logic [31:2] pc,
	output logic [31:2] pc_excep,
	output logic trap_take
);
	import cpu_ctrl_pkg::*;
	import trap_pkg::*;

	logic cpu_adr_ld;
	logic irq_latch;
	logic frc_leq_d;
	logic frc_latch;
	logic frc_rise;
	logic trap_cond;
	logic jump_cond;
	logic [31:2] pc_p1;
	logic [31:2] jmp_adr;
	logic [31:2] pc_ecall;

	assign pc_p1 = pc + adr_w'(1);

	// synchronous traps plus the latched asynchronous ones
	assign trap_cond = ex_result.ecall | ex_result.exception | irq_latch | frc_latch;
	assign jump_cond = ex_result.jmp_condition | ex_result.mret | ex_result.sret
		| ex_result.uret;

	// uret has no target of its own
	always_comb begin
		if (trap_cond)
			jmp_adr = vec.mtvec;
		else if (ex_result.mret)
			jmp_adr = vec.mepc;
		else if (ex_result.sret)
			jmp_adr = vec.sepc;
		else
			jmp_adr = ex_result.jmp_adr;
	end

	// start address pending until the first pc update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cpu_adr_ld <= 1'b0;
		else if (cpu_stat_pc)
			cpu_adr_ld <= 1'b0;
		else if (cpu_start)
			cpu_adr_ld <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (cpu_stat_pc & cpu_adr_ld)
			pc <= cpu_start_adr;
		else if (cpu_stat_pc & (trap_cond | jump_cond))
			pc <= jmp_adr;
		else if (cpu_stat_pc)
			pc <= pc_p1;
	end

	// start load outranks a trap, so no capture then
	assign trap_take = cpu_stat_pc & trap_cond & ~cpu_adr_ld;

	// ecall pc taken during execute, ready by pc_upd
	always_ff @(posedge clk) begin
		if (ex_result.ecall & ~cpu_stat_pc)
			pc_ecall <= pc;
	end

	assign pc_excep = (ex_result.ecall & ~irq.level & ~frc_leq) ? pc_ecall :
		cpu_stat_pc ? pc : pc_p1;

	// interrupt held until an update takes it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_latch <= 1'b0;
		else if (irq.one_shot)
			irq_latch <= 1'b1;
		else if (cpu_stat_pc)
			irq_latch <= 1'b0;
	end

	// timer flag rising edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frc_leq_d <= 1'b0;
		else
			frc_leq_d <= frc_leq;
	end

	assign frc_rise = frc_leq & ~frc_leq_d;

	// a rise during an update stays for the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			frc_latch <= 1'b0;
		else if (frc_rise)
			frc_latch <= 1'b1;
		else if (cpu_stat_pc)
			frc_latch <= 1'b0;
	end

	a_pc_upd_only: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(pc) |-> $past(cpu_stat_pc))
		else $error("pc changed outside a pc update");

endmodule

// ==== src/pc_subsys_top.sv ====
/*
 * pc subsystem top
 * sequencer, timer, trap registers and pc stage wired together
 */
`timescale 1ns/10ps

module pc_subsys_top (
	input logic clk,
	input logic rst_n,
	input logic cpu_start,
	input logic [31:2] cpu_start_adr,
	input logic stall,
	input cpu_ctrl_pkg::ex_result_t ex_result,
	input logic irq_in,
	input trap_pkg::csr_wr_t csr_wr,
	output logic [31:2] pc,
	output logic [31:2] pc_excep,
	output logic cpu_stat_pc,
	output logic trap_take
);
	import trap_pkg::*;

	logic frc_leq;
	irq_t irq;
	trap_vec_t vec;

	cpu_state_seq u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_start(cpu_start),
		.stall(stall),
		.cpu_stat_pc(cpu_stat_pc)
	);

	frc_timer u_frc (
		.clk(clk),
		.rst_n(rst_n),
		.csr_wr(csr_wr),
		.frc_leq(frc_leq)
	);

	// mepc fed back from the pc stage on a trap
	trap_csr_regs u_csr (
		.clk(clk),
		.rst_n(rst_n),
		.csr_wr(csr_wr),
		.irq_in(irq_in),
		.trap_take(trap_take),
		.pc_excep(pc_excep),
		.irq(irq),
		.vec(vec)
	);

	pc_stage u_pc (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_start(cpu_start),
		.cpu_stat_pc(cpu_stat_pc),
		.cpu_start_adr(cpu_start_adr),
		.ex_result(ex_result),
		.irq(irq),
		.frc_leq(frc_leq),
		.vec(vec),
		.pc(pc),
		.pc_excep(pc_excep),
		.trap_take(trap_take)
	);

endmodule

// ==== sim/tb_pc_subsys.sv ====
/*
 * pc subsystem testbench
 * start, stall, redirects, traps, interrupt and timer against a next-pc model
 */
`timescale 1ns/10ps

module tb_pc_subsys;
	import cpu_ctrl_pkg::*;
	import trap_pkg::*;

	logic clk = 1'b0;
	logic rst_n, cpu_start, stall, irq_in;
	logic [31:2] cpu_start_adr;
	ex_result_t ex_result;
	csr_wr_t csr_wr;
	logic [31:2] pc, pc_excep;
	logic cpu_stat_pc, trap_take;

	// model state
	logic [31:2] pc_m, start_adr_m, mtvec_m, mepc_m, sepc_m;
	logic start_pend, irq_pend, frc_pend;
	int seed = 32'h590c9f2c;
	int cyc = 0, last_cyc = 0, upd_gap = 0, upd_count = 0;
	int err_cnt = 0, chk_cnt = 0, test_cnt = 0, err_mark = 0;
	string cur_test = "reset";

	pc_subsys_top uut (.*);

	always #10 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	// priority: start, trap, mret, sret, jump or uret, pc plus one
	function automatic logic [31:2] ref_next_pc(input logic [31:2] cur, input ex_result_t ex,
		input logic start_p, input logic irq_p, input logic frc_p);
		logic trap;
		trap = ex.ecall | ex.exception | irq_p | frc_p;
		if (start_p) return start_adr_m;
		if (trap) return mtvec_m;
		if (ex.mret) return mepc_m;
		if (ex.sret) return sepc_m;
		if (ex.jmp_condition | ex.uret) return ex.jmp_adr;
		return cur + 30'd1;
	endfunction

	task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		chk_cnt++;
		assert (exp_v == act_v) else begin
			$display("error %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
			err_cnt++;
		end
	endtask

	// returns at posedge + 2 ns, in decode
	task automatic wait_update();
		int c0;
		int t;
		cpu_phase_e ph;
		c0 = upd_count;
		t = 0;
		while (upd_count == c0 && t < 100) begin
			@(posedge clk);
			t++;
		end
		if (upd_count == c0) begin
			ph = uut.u_seq.phase;
			$display("timeout: no pc update in test %s, phase %s", cur_test, ph.name());
			$display("Testbench failed");
			$finish;
		end else begin
			#2;
		end
	endtask

	task automatic run_instr(input ex_result_t ex);
		ex_result = ex;
		stall = 1'b0;
		wait_update();
	endtask

	// stall raised inside pc_upd, still one update, returns in decode
	task automatic stall_in_update(input int n);
		int c0;
		int t;
		c0 = upd_count;
		ex_result = '0;
		stall = 1'b0;
		t = 0;
		while (!cpu_stat_pc && t < 100) begin
			@(posedge clk);
			#2;
			t++;
		end
		if (!cpu_stat_pc) begin
			$display("timeout: no pc_upd phase reached in test %s", cur_test);
			$display("Testbench failed");
			$finish;
		end else begin
			stall = 1'b1;
			repeat (n) @(posedge clk);
			#2;
			stall = 1'b0;
			// pc_upd, fetch, then decode
			repeat (2) @(posedge clk);
			#2;
			check("updates in stalled pc_upd", 32'd1, 32'(upd_count - c0));
		end
	endtask

	// one-cycle strobe, model copy follows
	task automatic csr_write(input csr_sel_e sel, input logic [31:0] data);
		csr_wr = '{en: 1'b1, sel: sel, data: data};
		@(posedge clk);
		#2;
		csr_wr.en = 1'b0;
		case (sel)
			csr_mtvec: mtvec_m = data[31:2];
			csr_mepc: mepc_m = data[31:2];
			csr_sepc: sepc_m = data[31:2];
			default: ;
		endcase
	endtask

	// small compare gives a rising flag, large one none
	task automatic arm_timer(input logic [31:0] cmp, input logic rises);
		stall = 1'b1;
		csr_write(csr_frc_cmp, cmp);
		repeat (6) @(posedge clk);
		#2;
		frc_pend = rises;
		run_instr('0);
	endtask

	task automatic end_test();
		if (err_cnt == err_mark)
			$display("%s: ok", cur_test);
		else
			$display("%s: %0d errors", cur_test, err_cnt - err_mark);
		test_cnt++;
		err_mark = err_cnt;
	endtask

	// compares every update one cycle after the pulse
	initial begin : compare_updates
		logic [31:2] exp_pc;
		logic exp_trap;
		forever begin
			@(negedge clk);
			if (rst_n && cpu_stat_pc) begin
				exp_pc = ref_next_pc(pc_m, ex_result, start_pend, irq_pend, frc_pend);
				exp_trap = !start_pend && (ex_result.ecall || ex_result.exception
					|| irq_pend || frc_pend);
				check("trap_take", 32'(exp_trap), 32'(trap_take));
				if (exp_trap) begin
					check("pc_excep", 32'(pc_m), 32'(pc_excep));
					mepc_m = pc_m;
				end
				upd_gap = cyc - last_cyc;
				last_cyc = cyc;
				@(negedge clk);
				check("pc", 32'(exp_pc), 32'(pc));
				pc_m = exp_pc;
				start_pend = 1'b0;
				irq_pend = 1'b0;
				frc_pend = 1'b0;
				upd_count++;
			end
		end
	end

	initial begin : watchdog
		for (int i = 0; i < 5000; i++)
			@(posedge clk);
		$display("simulation ran past its cycle limit");
		$display("Testbench failed");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] r;
		int n;
		ex_result_t ex;
		logic [31:2] ret_pc;
		rst_n = 1'b0;
		cpu_start = 1'b0;
		cpu_start_adr = '0;
		stall = 1'b0;
		ex_result = '0;
		irq_in = 1'b0;
		csr_wr = '0;
		{pc_m, mtvec_m, mepc_m, sepc_m} = '0;
		{start_pend, irq_pend, frc_pend} = '0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		// start load, then plain increments 4 cycles apart
		cur_test = "start";
		r = $random(seed);
		cpu_start_adr = r[31:2];
		start_adr_m = r[31:2];
		start_pend = 1'b1;
		cpu_start = 1'b1;
		@(posedge clk);
		#2;
		cpu_start = 1'b0;
		wait_update();
		for (int i = 0; i < 4; i++) begin
			run_instr('0);
			check("update spacing", 32'd4, 32'(upd_gap));
		end
		end_test();
		cur_test = "stall";
		for (int i = 0; i < 3; i++) begin
			n = ($random(seed) & 7) + 1;
			stall = 1'b1;
			repeat (n) @(posedge clk);
			#2;
			run_instr('0);
			check("update spacing", 32'(4 + n), 32'(upd_gap));
		end
		// stall held in pc_upd itself
		for (int i = 0; i < 3; i++) begin
			n = ($random(seed) & 7) + 1;
			stall_in_update(n);
			run_instr('0);
			check("update spacing", 32'(4 + n), 32'(upd_gap));
		end
		end_test();
		// csr writes under stall so they land before execute
		cur_test = "redirect";
		for (int i = 0; i < 8; i++) begin
			stall = 1'b1;
			csr_write(csr_mepc, $random(seed));
			csr_write(csr_sepc, $random(seed));
			r = $random(seed);
			ex = '0;
			{ex.jmp_condition, ex.mret, ex.sret, ex.uret} = r[3:0];
			r = $random(seed);
			ex.jmp_adr = r[31:2];
			run_instr(ex);
		end
		end_test();
		cur_test = "ecall/exception";
		for (int k = 0; k < 2; k++) begin
			stall = 1'b1;
			csr_write(csr_mtvec, $random(seed));
			ret_pc = pc_m;
			ex = '0;
			ex.ecall = (k == 0);
			ex.exception = (k == 1);
			run_instr(ex);
			ex = '0;
			ex.mret = 1'b1;
			run_instr(ex);
			check("mret return", 32'(ret_pc), 32'(pc));
		end
		end_test();
		// irq edge with irq_en set, then again with it clear
		cur_test = "interrupt";
		stall = 1'b1;
		csr_write(csr_irq_en, 32'd1);
		irq_in = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		irq_pend = 1'b1;
		run_instr('0);
		irq_in = 1'b0;
		stall = 1'b1;
		csr_write(csr_irq_en, 32'd0);
		irq_in = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		run_instr('0);
		irq_in = 1'b0;
		end_test();
		// a held flag traps once, a large compare rearms it
		cur_test = "timer";
		arm_timer(32'd0, 1'b1);
		run_instr('0);
		arm_timer(32'hffff_ffff, 1'b0);
		arm_timer(32'd0, 1'b1);
		end_test();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== files.f ====
src/cpu_ctrl_pkg.sv
src/trap_pkg.sv
src/cpu_state_seq.sv
src/frc_timer.sv
src/trap_csr_regs.sv
src/pc_stage.sv
src/pc_subsys_top.sv
sim/tb_pc_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pc subsystem testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_pc_subsys -f files.f

./obj_dir/Vtb_pc_subsys | tee sim.log

if grep -q "Testbench passed" sim.log; then
	exit 0
else
	exit 1
fi
